//--- Makefile
VERILATOR ?= verilator
TOP ?= tbArmOperandFetch
RTL_TOP ?= armOperandFetch
FILELIST ?= armOperandFetch.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- armOperandFetch.f
hw/archPkg.sv
hw/pipePkg.sv
hw/regFile.sv
hw/instDecode.sv
hw/operandStage.sv
hw/armOperandFetch.sv
tb/tbClock.sv
tb/tbArmOperandFetch.sv

//--- hw/archPkg.sv
package archPkg;

	// datapath width and register count
	localparam int WORD_W = 32;
	localparam int REG_COUNT = 16;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [3:0] regIdx_t;
	typedef logic [4:0] shamt_t;
	typedef logic [3:0] cond_t;

	// registers with a fixed role
	localparam regIdx_t LINK_REG = 4'd14;
	localparam regIdx_t PC_REG = 4'd15;

	// byte step of the program counter per instruction
	localparam word_t PC_STEP = 32'd4;

	// immediate extension formats
	// byte: inst[7:0] sign-extended
	// 12 bit: inst[11:0] zero-extended
	// branch: inst[23:0] word offset, sign-extended
	typedef enum logic [1:0] {
		IMM_BYTE_SEXT = 2'd0,
		IMM_12_ZEXT   = 2'd1,
		IMM_BRANCH    = 2'd2
	} immSrc_t;

endpackage

//--- hw/armOperandFetch.sv
`timescale 1ns/1ps

module armOperandFetch #(
	parameter archPkg::word_t RESET_PC = '0
) (
	input  logic                 clk,
	input  logic                 reset,
	input  archPkg::word_t       i_inst,
	input  logic                 i_stall,
	input  logic                 i_flush,
	input  pipePkg::decodeCtrl_t i_ctrl,
	input  logic                 i_branch,
	input  archPkg::word_t       i_branchTarget,
	input  pipePkg::wbPort_t     i_wb,
	output archPkg::word_t       o_pc,
	output pipePkg::operands_t   o_operands
);
	import archPkg::*;
	import pipePkg::*;

	regIdx_t rdAddr1;
	regIdx_t rdAddr2;
	word_t read1;
	word_t read2;
	decoded_t decoded;

	instDecode i_instDecode (
		.clk       (clk),
		.reset     (reset),
		.i_inst    (i_inst),
		.i_stall   (i_stall),
		.i_immSrc  (i_ctrl.immSrc),
		.i_regSrc1 (i_ctrl.regSrc1),
		.i_regSrc2 (i_ctrl.regSrc2),
		.o_rdAddr1 (rdAddr1),
		.o_rdAddr2 (rdAddr2),
		.o_decoded (decoded)
	);

	regFile #(
		.RESET_PC (RESET_PC)
	) i_regFile (
		.clk            (clk),
		.reset          (reset),
		.i_rdAddr1      (rdAddr1),
		.i_rdAddr2      (rdAddr2),
		.i_wb           (i_wb),
		.i_link         (i_ctrl.link),
		.i_stall        (i_stall),
		.i_branch       (i_branch),
		.i_branchTarget (i_branchTarget),
		.o_read1        (read1),
		.o_read2        (read2),
		.o_pc           (o_pc)
	);

	operandStage i_operandStage (
		.clk        (clk),
		.reset      (reset),
		.i_read1    (read1),
		.i_read2    (read2),
		.i_decoded  (decoded),
		.i_aluSrc1  (i_ctrl.aluSrc1),
		.i_aluSrc2  (i_ctrl.aluSrc2),
		.i_flush    (i_flush),
		.o_operands (o_operands)
	);

endmodule

//--- hw/instDecode.sv
`timescale 1ns/1ps

module instDecode (
	input  logic              clk,
	input  logic              reset,
	input  archPkg::word_t    i_inst,
	input  logic              i_stall,
	input  archPkg::immSrc_t  i_immSrc,
	input  logic              i_regSrc1,
	input  logic              i_regSrc2,
	output archPkg::regIdx_t  o_rdAddr1,
	output archPkg::regIdx_t  o_rdAddr2,
	output pipePkg::decoded_t o_decoded
);
	import archPkg::*;

	word_t inst;
	word_t imm;

	// fetch/decode stage register, frozen on stall
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			inst <= '0;
		end else if (!i_stall) begin
			inst <= i_inst;
		end
	end

	// Rn or the pc on port 1, Rm or Rd on port 2
	assign o_rdAddr1 = i_regSrc1 ? PC_REG : inst[19:16];
	assign o_rdAddr2 = i_regSrc2 ? inst[15:12] : inst[3:0];

	always_comb begin
		case (i_immSrc)
			IMM_BYTE_SEXT: begin
				imm = {{(WORD_W-8){inst[7]}}, inst[7:0]};
			end
			IMM_12_ZEXT: begin
				imm = {{(WORD_W-12){1'b0}}, inst[11:0]};
			end
			IMM_BRANCH: begin
				// word offset to byte offset
				imm = {{(WORD_W-26){inst[23]}}, inst[23:0], 2'b00};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

	assign o_decoded = '{
		imm:   imm,
		shamt: inst[11:7],
		rd:    inst[15:12],
		cond:  inst[31:28]
	};

	// control unit must never select the spare format
	immSrcLegal: assert property (
		@(posedge clk) disable iff (reset)
		i_immSrc inside {IMM_BYTE_SEXT, IMM_12_ZEXT, IMM_BRANCH}
	) else $error("instDecode: unused immediate format selected");

endmodule

//--- hw/operandStage.sv
`timescale 1ns/1ps

module operandStage (
	input  logic               clk,
	input  logic               reset,
	input  archPkg::word_t     i_read1,
	input  archPkg::word_t     i_read2,
	input  pipePkg::decoded_t  i_decoded,
	input  logic               i_aluSrc1,
	input  logic               i_aluSrc2,
	input  logic               i_flush,
	output pipePkg::operands_t o_operands
);
	import archPkg::*;
	import pipePkg::*;

	word_t shifted;
	operands_t nextOps;

	// shifter ahead of B, also the store data
	assign shifted = i_read2 << i_decoded.shamt;

	always_comb begin
		nextOps.valid = 1'b1;
		nextOps.a = i_aluSrc1 ? '0 : i_read1;
		nextOps.b = i_aluSrc2 ? shifted : i_decoded.imm;
		nextOps.writeData = shifted;
		nextOps.rd = i_decoded.rd;
		nextOps.cond = i_decoded.cond;
	end

	// decode/execute stage register, loads every cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_operands <= '0;
		end else if (i_flush) begin
			// bubble
			o_operands <= '0;
		end else begin
			o_operands <= nextOps;
		end
	end

endmodule

//--- hw/pipePkg.sv
package pipePkg;

	// decoded controls for the instruction held in fetch/decode
	typedef struct packed {
		archPkg::immSrc_t immSrc;
		// read PC_REG on port 1
		logic regSrc1;
		// read inst[15:12] on port 2
		logic regSrc2;
		// A forced to zero
		logic aluSrc1;
		// B from shifted read2
		logic aluSrc2;
		// branch-and-link
		logic link;
	} decodeCtrl_t;

	// register file write request from writeback
	typedef struct packed {
		logic en;
		archPkg::regIdx_t addr;
		archPkg::word_t data;
	} wbPort_t;

	// instruction fields carried from decode to the operand stage
	typedef struct packed {
		archPkg::word_t imm;
		archPkg::shamt_t shamt;
		archPkg::regIdx_t rd;
		archPkg::cond_t cond;
	} decoded_t;

	// bundle handed to execute
	typedef struct packed {
		logic valid;
		archPkg::word_t a;
		archPkg::word_t b;
		// shifted read2, the store data path
		archPkg::word_t writeData;
		archPkg::regIdx_t rd;
		archPkg::cond_t cond;
	} operands_t;

endpackage

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile #(
	parameter archPkg::word_t RESET_PC = '0
) (
	input  logic             clk,
	input  logic             reset,
	input  archPkg::regIdx_t i_rdAddr1,
	input  archPkg::regIdx_t i_rdAddr2,
	input  pipePkg::wbPort_t i_wb,
	input  logic             i_link,
	input  logic             i_stall,
	input  logic             i_branch,
	input  archPkg::word_t   i_branchTarget,
	output archPkg::word_t   o_read1,
	output archPkg::word_t   o_read2,
	output archPkg::word_t   o_pc
);
	import archPkg::*;

	word_t regs [REG_COUNT];
	logic wbGeneral;
	logic wbLink;
	logic wbPc;

	// writeback destination decode
	assign wbGeneral = i_wb.en && (i_wb.addr < LINK_REG);
	assign wbLink = i_wb.en && (i_wb.addr == LINK_REG);
	assign wbPc = i_wb.en && (i_wb.addr == PC_REG);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
			regs[PC_REG] <= RESET_PC;
		end else begin
			if (wbGeneral) begin
				regs[i_wb.addr] <= i_wb.data;
			end

			// link wins over a writeback to R14
			if (i_link) begin
				regs[LINK_REG] <= regs[PC_REG];
			end else if (wbLink) begin
				regs[LINK_REG] <= i_wb.data;
			end

			// pc: writeback, then branch, then stall, then step
			if (wbPc) begin
				regs[PC_REG] <= i_wb.data;
			end else if (i_branch) begin
				regs[PC_REG] <= i_branchTarget;
			end else if (!i_stall) begin
				regs[PC_REG] <= regs[PC_REG] + PC_STEP;
			end
		end
	end

	// no bypass, a write shows up after the edge
	assign o_read1 = regs[i_rdAddr1];
	assign o_read2 = regs[i_rdAddr2];
	assign o_pc = regs[PC_REG];

	// a writeback to R14 in a link cycle would be lost
	linkWbExclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(i_link && wbLink)
	) else $error("regFile: link and writeback to R14 in the same cycle");

endmodule

//--- tb/tbArmOperandFetch.sv
`timescale 1ns/1ps

module tbArmOperandFetch;
	import archPkg::*;
	import pipePkg::*;

	localparam word_t RESET_PC = 32'h0000_1000;
	localparam int PERIOD_NS = 4;
	// cycles per test, used to size the watchdog
	localparam int RESET_LEN = 6;
	localparam int PC_LEN = 24;
	localparam int RD_ITER = 24;
	localparam int RD_LEN = RD_ITER * 2 + 4;
	localparam int IMM_ITER = 15;
	localparam int IMM_LEN = IMM_ITER + 4;
	localparam int LINK_LEN = 12;
	localparam int FLUSH_LEN = 16;
	localparam int TOTAL_CYCLES = RESET_LEN + PC_LEN + RD_LEN + IMM_LEN + LINK_LEN + FLUSH_LEN;
	localparam int MARGIN = 50;

	logic clk;
	logic reset;
	word_t i_inst;
	logic i_stall;
	logic i_flush;
	decodeCtrl_t i_ctrl;
	logic i_branch;
	word_t i_branchTarget;
	wbPort_t i_wb;
	word_t o_pc;
	operands_t o_operands;

	// reference model state
	word_t mRegs [15];
	word_t mPc;
	word_t mInst;
	operands_t mOps;

	int seed = 97;
	int errors = 0;
	int passCount = 0;
	int failCount = 0;
	int errAtStart;
	string testName = "reset";

	tbClock #(.PERIOD(PERIOD_NS), .RESET_CYCLES(2)) i_tbClock (
		.o_clk   (clk),
		.o_reset (reset)
	);

	armOperandFetch #(
		.RESET_PC (RESET_PC)
	) i_armOperandFetch (
		.clk            (clk),
		.reset          (reset),
		.i_inst         (i_inst),
		.i_stall        (i_stall),
		.i_flush        (i_flush),
		.i_ctrl         (i_ctrl),
		.i_branch       (i_branch),
		.i_branchTarget (i_branchTarget),
		.i_wb           (i_wb),
		.o_pc           (o_pc),
		.o_operands     (o_operands)
	);

	function automatic word_t readReg(input regIdx_t idx);
		if (idx == PC_REG) begin
			return mPc;
		end
		return mRegs[idx];
	endfunction

	function automatic word_t extendImm(input word_t inst, input immSrc_t src);
		word_t branchOff;
		branchOff = {{8{inst[23]}}, inst[23:0]};
		case (src)
			IMM_BYTE_SEXT: return {{24{inst[7]}}, inst[7:0]};
			IMM_12_ZEXT: return {20'd0, inst[11:0]};
			default: return branchOff << 2;
		endcase
	endfunction

	// cycle model of decode, register file and operand register
	always @(posedge clk or posedge reset) begin
		regIdx_t addr1;
		regIdx_t addr2;
		word_t shifted;
		if (reset) begin
			for (int i = 0; i < 15; i++) begin
				mRegs[i] <= '0;
			end
			mPc <= RESET_PC;
			mInst <= '0;
			mOps <= '0;
		end else begin
			addr1 = i_ctrl.regSrc1 ? PC_REG : mInst[19:16];
			addr2 = i_ctrl.regSrc2 ? mInst[15:12] : mInst[3:0];
			shifted = readReg(addr2) << mInst[11:7];
			if (i_flush) begin
				mOps <= '0;
			end else begin
				mOps.valid <= 1'b1;
				mOps.a <= i_ctrl.aluSrc1 ? 32'd0 : readReg(addr1);
				mOps.b <= i_ctrl.aluSrc2 ? shifted : extendImm(mInst, i_ctrl.immSrc);
				mOps.writeData <= shifted;
				mOps.rd <= mInst[15:12];
				mOps.cond <= mInst[31:28];
			end
			if (i_wb.en && i_wb.addr < LINK_REG) begin
				mRegs[i_wb.addr] <= i_wb.data;
			end
			if (i_ctrl.link) begin
				mRegs[LINK_REG] <= mPc;
			end else if (i_wb.en && i_wb.addr == LINK_REG) begin
				mRegs[LINK_REG] <= i_wb.data;
			end
			if (i_wb.en && i_wb.addr == PC_REG) begin
				mPc <= i_wb.data;
			end else if (i_branch) begin
				mPc <= i_branchTarget;
			end else if (!i_stall) begin
				mPc <= mPc + PC_STEP;
			end
			if (!i_stall) begin
				mInst <= i_inst;
			end
		end
	end

	pcMatches: assert property (@(posedge clk) disable iff (reset) o_pc == mPc)
	else begin
		$display("mismatch %s pc expected %h actual %h", testName, mPc, o_pc);
		errors++;
	end

	operandsMatch: assert property (@(posedge clk) disable iff (reset) o_operands == mOps)
	else begin
		$display("mismatch %s operands expected %h actual %h", testName, mOps, o_operands);
		errors++;
	end

	task automatic drive(input word_t inst, input decodeCtrl_t ctrl, input logic stall,
			input logic flush, input logic branch, input word_t target, input wbPort_t wb);
		@(posedge clk);
		i_inst <= inst;
		i_ctrl <= ctrl;
		i_stall <= stall;
		i_flush <= flush;
		i_branch <= branch;
		i_branchTarget <= target;
		i_wb <= wb;
	endtask

	task automatic idle(input int n);
		repeat (n) drive('0, '0, 1'b0, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic startTest(input string name);
		testName = name;
		errAtStart = errors;
	endtask

	task automatic endTest();
		// let the last instruction drain through both stages
		idle(3);
		if (errors == errAtStart) begin
			passCount++;
			$display("test %s: ok", testName);
		end else begin
			failCount++;
			$display("test %s: %0d errors", testName, errors - errAtStart);
		end
	endtask

	initial begin
		decodeCtrl_t ctrl;
		word_t inst;
		word_t data;
		regIdx_t r;
		i_inst = '0;
		i_stall = 1'b0;
		i_flush = 1'b0;
		i_ctrl = '0;
		i_branch = 1'b0;
		i_branchTarget = '0;
		i_wb = '0;
		@(negedge reset);

		startTest("reset");
		endTest();

		startTest("pc");
		idle(3);
		drive('0, '0, 1'b1, 1'b1, 1'b0, '0, '0);
		drive('0, '0, 1'b1, 1'b1, 1'b0, '0, '0);
		drive('0, '0, 1'b0, 1'b0, 1'b1, 32'h0000_2340, '0);
		idle(2);
		drive('0, '0, 1'b0, 1'b0, 1'b0, '0, '{en: 1'b1, addr: PC_REG, data: 32'h0000_8000});
		// writeback to the pc beats a branch
		drive('0, '0, 1'b1, 1'b0, 1'b1, 32'h0000_0400, '{en: 1'b1, addr: PC_REG, data: 32'h0000_0C00});
		drive('0, '0, 1'b1, 1'b0, 1'b1, 32'h0000_0500, '0);
		idle(2);
		endTest();

		startTest("regRead");
		ctrl = '{immSrc: IMM_BYTE_SEXT, regSrc1: 1'b0, regSrc2: 1'b1,
			aluSrc1: 1'b0, aluSrc2: 1'b1, link: 1'b0};
		for (int n = 0; n < RD_ITER; n++) begin
			r = regIdx_t'($unsigned($random(seed)) % 14);
			data = $random(seed);
			inst = $random(seed);
			inst[19:16] = r;
			inst[15:12] = r;
			drive('0, ctrl, 1'b0, 1'b0, 1'b0, '0, '{en: 1'b1, addr: r, data: data});
			drive(inst, ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		end
		endTest();

		startTest("immediate");
		for (int n = 0; n < IMM_ITER; n++) begin
			ctrl = '{immSrc: immSrc_t'(n % 3), regSrc1: 1'b0, regSrc2: 1'b0,
				aluSrc1: n[0], aluSrc2: 1'b0, link: 1'b0};
			drive($random(seed), ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		end
		endTest();

		startTest("link");
		ctrl = '{immSrc: IMM_BRANCH, regSrc1: 1'b0, regSrc2: 1'b0,
			aluSrc1: 1'b0, aluSrc2: 1'b0, link: 1'b1};
		drive(32'h0A00_0010, ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		ctrl.link = 1'b0;
		inst = $random(seed);
		inst[19:16] = LINK_REG;
		drive(inst, ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		drive('0, ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		ctrl.regSrc1 = 1'b1;
		drive($random(seed), ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		drive($random(seed), ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		endTest();

		startTest("flush");
		ctrl = '{immSrc: IMM_12_ZEXT, regSrc1: 1'b0, regSrc2: 1'b1,
			aluSrc1: 1'b0, aluSrc2: 1'b1, link: 1'b0};
		drive($random(seed), ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		drive($random(seed), ctrl, 1'b0, 1'b1, 1'b0, '0, '0);
		// bubble while the held instruction waits
		drive($random(seed), ctrl, 1'b1, 1'b1, 1'b0, '0, '0);
		drive($random(seed), ctrl, 1'b1, 1'b1, 1'b0, '0, '0);
		drive($random(seed), ctrl, 1'b1, 1'b0, 1'b0, '0, '0);
		drive($random(seed), ctrl, 1'b0, 1'b0, 1'b0, '0, '0);
		endTest();

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0 && errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#((TOTAL_CYCLES + MARGIN) * PERIOD_NS);
		$display("timeout: the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- tb/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter realtime PERIOD = 4.0,
	parameter int RESET_CYCLES = 2
) (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD / 2.0) o_clk = ~o_clk;
		end
	end

	// reset released on a rising edge after the hold time
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule
